// File: rtl/cache_consts.svh
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// address split: tag | index | byte offset
`define CACHE_ADDR_W 32
`define CACHE_TAG_W 21
`define CACHE_IDX_W 6
`define CACHE_OFF_W 5
`define CACHE_SETS 64

// line geometry, four words of 64 bits
`define CACHE_WORD_W 64
`define CACHE_MASK_W 8
`define CACHE_BEATS 4
`define CACHE_WSEL_W 2
`define CACHE_LINE_W 256

`define CACHE_WAYS 2
`define CACHE_WAY_W 1

`endif

// File: rtl/cache_pkg.sv
`default_nettype none
`include "cache_consts.svh"

package cache_pkg;

  // address fields as seen by the tag and data arrays
  typedef struct packed {
    logic [`CACHE_TAG_W-1:0] tag;
    logic [`CACHE_IDX_W-1:0] idx;
    logic [`CACHE_OFF_W-1:0] off;
  } addrFields_t;

  // one address word, either raw or split into fields
  typedef union packed {
    logic [`CACHE_ADDR_W-1:0] raw;
    addrFields_t              f;
  } cacheAddr_u;

  // accepted pipeline request, op is 1 for a store
  typedef struct packed {
    logic                     op;
    cacheAddr_u               addr;
    logic [`CACHE_WORD_W-1:0] wdata;
    logic [`CACHE_MASK_W-1:0] wmask;
  } cacheReq_t;

  // single memory beat of a refill burst
  typedef struct packed {
    logic [`CACHE_WORD_W-1:0] data;
    logic                     last;
  } refillBeat_t;

endpackage

`default_nettype wire

// File: rtl/cacheTagArray.sv
`timescale 1ns/10ps
`default_nettype none
`include "cache_consts.svh"

module cacheTagArray (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire logic                    lookup_i,
  input  wire logic [`CACHE_IDX_W-1:0] lookupIdx_i,
  input  wire logic [`CACHE_TAG_W-1:0] lookupTag_i,
  input  wire logic                    tagWr_i,
  input  wire logic [`CACHE_WAY_W-1:0] wrWay_i,
  input  wire logic [`CACHE_TAG_W-1:0] wrTag_i,
  input  wire logic                    touch_i,
  input  wire logic [`CACHE_WAY_W-1:0] touchWay_i,
  output logic                         hit_o,
  output logic      [`CACHE_WAY_W-1:0] hitWay_o,
  output logic      [`CACHE_WAY_W-1:0] victimWay_o
);

  logic [`CACHE_TAG_W-1:0]                   tagMem [`CACHE_WAYS][`CACHE_SETS];
  logic [`CACHE_WAYS-1:0][`CACHE_SETS-1:0]   validQ;
  // per set, the way to evict next
  logic [`CACHE_SETS-1:0]                    lruQ;
  logic [`CACHE_IDX_W-1:0]                   lkIdxQ;
  logic [`CACHE_WAYS-1:0]                    hitVecQ;
  logic [`CACHE_WAYS-1:0]                    wayHit;

  always_comb begin
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      wayHit[w] = validQ[w][lookupIdx_i] && (tagMem[w][lookupIdx_i] == lookupTag_i);
    end
  end

  always_ff @(posedge clk) begin
    if (tagWr_i) begin
      tagMem[wrWay_i][lookupIdx_i] <= wrTag_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ  <= '0;
      lruQ    <= '0;
      lkIdxQ  <= '0;
      hitVecQ <= '0;
    end else begin
      if (lookup_i) begin
        lkIdxQ  <= lookupIdx_i;
        hitVecQ <= wayHit;
      end
      // a fill counts as a use of the new way
      if (tagWr_i) begin
        validQ[wrWay_i][lookupIdx_i] <= 1'b1;
        lruQ[lookupIdx_i]            <= ~wrWay_i;
      end else if (touch_i) begin
        lruQ[lkIdxQ] <= ~touchWay_i;
      end
    end
  end

  assign hit_o    = |hitVecQ;
  // two ways, so the upper hit bit is the way number
  assign hitWay_o = hitVecQ[1];
  // follows same-cycle touches of the compared set
  assign victimWay_o = lruQ[lkIdxQ];

  oneWayHit: assert property (@(posedge clk) disable iff (!rst_n)
    lookup_i |=> !(hitVecQ[0] && hitVecQ[1]))
    else $error("tag array: both ways hit in one set");

endmodule

`default_nettype wire

// File: rtl/cacheDataArray.sv
`timescale 1ns/10ps
`default_nettype none
`include "cache_consts.svh"

module cacheDataArray (
  input  wire logic                                     clk,
  input  wire logic                                     rd_i,
  input  wire logic [`CACHE_IDX_W-1:0]                  rdIdx_i,
  input  wire logic                                     lineWr_i,
  input  wire logic                                     wordWr_i,
  input  wire logic [`CACHE_WAY_W-1:0]                  wrWay_i,
  input  wire logic [`CACHE_IDX_W-1:0]                  wrIdx_i,
  input  wire logic [`CACHE_WSEL_W-1:0]                 wrOff_i,
  input  wire logic [`CACHE_LINE_W-1:0]                 wrLine_i,
  input  wire logic [`CACHE_WORD_W-1:0]                 wrWord_i,
  input  wire logic [`CACHE_MASK_W-1:0]                 wrMask_i,
  output logic      [`CACHE_WAYS-1:0][`CACHE_LINE_W-1:0] lines_o
);

  // behavioral stand-in for the line SRAMs
  logic [`CACHE_LINE_W-1:0]                   lineMem [`CACHE_WAYS][`CACHE_SETS];
  logic [`CACHE_WAYS-1:0][`CACHE_LINE_W-1:0]  linesQ;

  always_ff @(posedge clk) begin
    if (lineWr_i) begin
      lineMem[wrWay_i][wrIdx_i] <= wrLine_i;
    end else if (wordWr_i) begin
      // store merge, one byte lane per mask bit
      for (int b = 0; b < `CACHE_MASK_W; b++) begin
        if (wrMask_i[b]) begin
          lineMem[wrWay_i][wrIdx_i][wrOff_i*`CACHE_WORD_W + b*8 +: 8] <= wrWord_i[b*8 +: 8];
        end
      end
    end
  end

  // both ways read together, the hit way is picked later
  always_ff @(posedge clk) begin
    if (rd_i) begin
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        linesQ[w] <= lineMem[w][rdIdx_i];
      end
    end
  end

  assign lines_o = linesQ;

endmodule

`default_nettype wire

// File: rtl/cacheRefill.sv
`timescale 1ns/10ps
`default_nettype none
`include "cache_consts.svh"

module cacheRefill (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire cache_pkg::refillBeat_t    beat_i,
  input  wire logic                      beatValid_i,
  output logic      [`CACHE_LINE_W-1:0]  line_o,
  output logic                           lineDone_o
);

  logic [`CACHE_BEATS-1:0][`CACHE_WORD_W-1:0] wordsQ;
  logic [`CACHE_BEATS-1:0][`CACHE_WORD_W-1:0] lineWords;
  logic [`CACHE_WSEL_W-1:0]                   beatCntQ;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCntQ <= '0;
    end else if (beatValid_i) begin
      // wraps to zero after the last beat
      beatCntQ <= beat_i.last ? '0 : beatCntQ + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (beatValid_i) begin
      wordsQ[beatCntQ] <= beat_i.data;
    end
  end

  // last beat goes straight into the line so it can be written this cycle
  always_comb begin
    lineWords = wordsQ;
    if (beatValid_i) begin
      lineWords[beatCntQ] = beat_i.data;
    end
  end

  assign line_o     = lineWords;
  assign lineDone_o = beatValid_i && beat_i.last;

  lastOnFourth: assert property (@(posedge clk) disable iff (!rst_n)
    beatValid_i |-> (beat_i.last == (beatCntQ == `CACHE_BEATS-1)))
    else $error("refill: last flag not on the fourth beat");

endmodule

`default_nettype wire

// File: rtl/cacheCtrl.sv
`timescale 1ns/10ps
`default_nettype none
`include "cache_consts.svh"

module cacheCtrl (
  input  wire logic                                      clk,
  input  wire logic                                      rst_n,
  // pipeline side
  input  wire logic                                      valid_i,
  input  wire logic                                      op_i,
  input  wire logic [`CACHE_ADDR_W-1:0]                  addr_i,
  input  wire logic [`CACHE_WORD_W-1:0]                  wr_data_i,
  input  wire logic [`CACHE_MASK_W-1:0]                  wr_mask_i,
  output logic                                           addr_ok_o,
  output logic                                           data_ok_o,
  output logic      [`CACHE_WORD_W-1:0]                  rd_data_o,
  // memory side
  output logic                                           cacheRdValid_o,
  output logic      [`CACHE_ADDR_W-1:0]                  cacheAddr_o,
  // tag array
  output logic                                           lookup_o,
  output logic      [`CACHE_IDX_W-1:0]                   lookupIdx_o,
  output logic      [`CACHE_TAG_W-1:0]                   lookupTag_o,
  input  wire logic                                      hit_i,
  input  wire logic [`CACHE_WAY_W-1:0]                   hitWay_i,
  input  wire logic [`CACHE_WAY_W-1:0]                   victimWay_i,
  output logic                                           touch_o,
  output logic      [`CACHE_WAY_W-1:0]                   touchWay_o,
  // data array and refill
  input  wire logic [`CACHE_WAYS-1:0][`CACHE_LINE_W-1:0] lines_i,
  input  wire logic                                      lineDone_i,
  input  wire logic [`CACHE_LINE_W-1:0]                  refillLine_i,
  output logic                                           tagWr_o,
  output logic                                           lineWr_o,
  output logic                                           wordWr_o,
  output logic      [`CACHE_WAY_W-1:0]                   wrWay_o,
  output logic      [`CACHE_TAG_W-1:0]                   wrTag_o,
  output logic      [`CACHE_LINE_W-1:0]                  wrLine_o,
  output logic      [`CACHE_WORD_W-1:0]                  wrWord_o,
  output logic      [`CACHE_MASK_W-1:0]                  wrMask_o,
  output logic      [`CACHE_WSEL_W-1:0]                  wrOff_o
);

  localparam logic [1:0] StIdle    = 2'd0;
  localparam logic [1:0] StCompare = 2'd1;
  localparam logic [1:0] StMiss    = 2'd2;
  localparam logic [1:0] StRefill  = 2'd3;

  logic [1:0]                state;
  logic [1:0]                stateNext;
  cache_pkg::cacheAddr_u     inAddr;
  cache_pkg::cacheReq_t      reqQ;
  logic                      accept;
  logic                      cmpHit;
  logic [`CACHE_WORD_W-1:0]  selWord;
  logic                      dataOkQ;
  logic [`CACHE_WORD_W-1:0]  rdDataQ;

  assign inAddr.raw = addr_i;
  assign cmpHit     = (state == StCompare) && hit_i;

  // a store hit blocks the next request until its merge is written
  assign addr_ok_o = (state == StIdle) || (cmpHit && !reqQ.op);
  assign accept    = valid_i && addr_ok_o;

  always_ff @(posedge clk) begin
    if (accept) begin
      reqQ.op    <= op_i;
      reqQ.addr  <= inAddr;
      reqQ.wdata <= wr_data_i;
      reqQ.wmask <= wr_mask_i;
    end
  end

  always_comb begin
    stateNext = state;
    case (state)
      StIdle: begin
        if (accept) begin
          stateNext = StCompare;
        end
      end
      StCompare: begin
        if (!hit_i) begin
          stateNext = StMiss;
        end else if (!accept) begin
          stateNext = StIdle;
        end
      end
      StMiss: begin
        if (lineDone_i) begin
          stateNext = StRefill;
        end
      end
      default: begin
        // re-lookup after the line is in place
        stateNext = StCompare;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= StIdle;
      dataOkQ <= 1'b0;
    end else begin
      state   <= stateNext;
      dataOkQ <= cmpHit;
    end
  end

  // lookups use the new address on accept, else the held request
  assign lookup_o    = accept || (state == StRefill);
  assign lookupIdx_o = accept ? inAddr.f.idx : reqQ.addr.f.idx;
  assign lookupTag_o = accept ? inAddr.f.tag : reqQ.addr.f.tag;

  // word offset bits of the held request
  assign wrOff_o = reqQ.addr.f.off[`CACHE_OFF_W-1 -: `CACHE_WSEL_W];
  assign selWord = lines_i[hitWay_i][wrOff_o*`CACHE_WORD_W +: `CACHE_WORD_W];

  always_ff @(posedge clk) begin
    if (cmpHit) begin
      rdDataQ <= selWord;
    end
  end

  assign data_ok_o = dataOkQ;
  assign rd_data_o = rdDataQ;

  assign touch_o    = cmpHit;
  assign touchWay_o = hitWay_i;

  // fill the victim on the beat that completes the line
  assign tagWr_o  = (state == StMiss) && lineDone_i;
  assign lineWr_o = tagWr_o;
  assign wordWr_o = cmpHit && reqQ.op;
  assign wrWay_o  = (state == StMiss) ? victimWay_i : hitWay_i;
  assign wrTag_o  = reqQ.addr.f.tag;
  assign wrLine_o = refillLine_i;
  assign wrWord_o = reqQ.wdata;
  assign wrMask_o = reqQ.wmask;

  assign cacheRdValid_o = (state == StMiss);
  assign cacheAddr_o    = {reqQ.addr.f.tag, reqQ.addr.f.idx, {`CACHE_OFF_W{1'b0}}};

  dataOkFromCompare: assert property (@(posedge clk) disable iff (!rst_n)
    data_ok_o |-> $past(state) == StCompare)
    else $error("ctrl: data_ok_o without a compare hit");

  missReqHeld: assert property (@(posedge clk) disable iff (!rst_n)
    (cacheRdValid_o && !lineDone_i) |=> (cacheRdValid_o && $stable(cacheAddr_o)))
    else $error("ctrl: memory request dropped before the last beat");

endmodule

`default_nettype wire

// File: rtl/cacheTop.sv
`timescale 1ns/10ps
`default_nettype none
`include "cache_consts.svh"

module cacheTop (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire logic                     valid_i,
  input  wire logic                     op_i,
  input  wire logic [`CACHE_ADDR_W-1:0] addr_i,
  input  wire logic [`CACHE_WORD_W-1:0] wr_data_i,
  input  wire logic [`CACHE_MASK_W-1:0] wr_mask_i,
  output logic                          addr_ok_o,
  output logic                          data_ok_o,
  output logic      [`CACHE_WORD_W-1:0] rd_data_o,
  output logic                          cacheRdValid_o,
  output logic      [`CACHE_ADDR_W-1:0] cacheAddr_o,
  input  wire logic                     rdDataValid_i,
  input  wire logic                     rdLast_i,
  input  wire logic [`CACHE_WORD_W-1:0] rdData_i
);

  logic                                      lookup;
  logic [`CACHE_IDX_W-1:0]                   lookupIdx;
  logic [`CACHE_TAG_W-1:0]                   lookupTag;
  logic                                      hit;
  logic [`CACHE_WAY_W-1:0]                   hitWay;
  logic [`CACHE_WAY_W-1:0]                   victimWay;
  logic                                      touch;
  logic [`CACHE_WAY_W-1:0]                   touchWay;
  logic [`CACHE_WAYS-1:0][`CACHE_LINE_W-1:0] lines;
  logic                                      lineDone;
  logic [`CACHE_LINE_W-1:0]                  refillLine;
  logic                                      tagWr;
  logic                                      lineWr;
  logic                                      wordWr;
  logic [`CACHE_WAY_W-1:0]                   wrWay;
  logic [`CACHE_TAG_W-1:0]                   wrTag;
  logic [`CACHE_LINE_W-1:0]                  wrLine;
  logic [`CACHE_WORD_W-1:0]                  wrWord;
  logic [`CACHE_MASK_W-1:0]                  wrMask;
  logic [`CACHE_WSEL_W-1:0]                  wrOff;
  cache_pkg::refillBeat_t                    beat;

  assign beat.data = rdData_i;
  assign beat.last = rdLast_i;

  cacheCtrl ctrl (
    .clk, .rst_n,
    .valid_i, .op_i, .addr_i, .wr_data_i, .wr_mask_i,
    .addr_ok_o, .data_ok_o, .rd_data_o,
    .cacheRdValid_o, .cacheAddr_o,
    .lookup_o(lookup), .lookupIdx_o(lookupIdx), .lookupTag_o(lookupTag),
    .hit_i(hit), .hitWay_i(hitWay), .victimWay_i(victimWay),
    .touch_o(touch), .touchWay_o(touchWay),
    .lines_i(lines), .lineDone_i(lineDone), .refillLine_i(refillLine),
    .tagWr_o(tagWr), .lineWr_o(lineWr), .wordWr_o(wordWr),
    .wrWay_o(wrWay), .wrTag_o(wrTag), .wrLine_o(wrLine),
    .wrWord_o(wrWord), .wrMask_o(wrMask), .wrOff_o(wrOff)
  );

  cacheTagArray tags (
    .clk, .rst_n,
    .lookup_i(lookup), .lookupIdx_i(lookupIdx), .lookupTag_i(lookupTag),
    .tagWr_i(tagWr), .wrWay_i(wrWay), .wrTag_i(wrTag),
    .touch_i(touch), .touchWay_i(touchWay),
    .hit_o(hit), .hitWay_o(hitWay), .victimWay_o(victimWay)
  );

  // writes never overlap a lookup, so reads and writes share one index
  cacheDataArray data (
    .clk,
    .rd_i(lookup), .rdIdx_i(lookupIdx),
    .lineWr_i(lineWr), .wordWr_i(wordWr), .wrWay_i(wrWay),
    .wrIdx_i(lookupIdx), .wrOff_i(wrOff), .wrLine_i(wrLine),
    .wrWord_i(wrWord), .wrMask_i(wrMask),
    .lines_o(lines)
  );

  cacheRefill refill (
    .clk, .rst_n,
    .beat_i(beat), .beatValid_i(rdDataValid_i),
    .line_o(refillLine), .lineDone_o(lineDone)
  );

endmodule

`default_nettype wire

// File: tests/cacheMemModel.sv
`timescale 1ns/10ps
`include "cache_consts.svh"
`default_nettype none

module cacheMemModel (
  input  wire logic                     clk,
  input  wire logic                     reqValid_i,
  input  wire logic [`CACHE_ADDR_W-1:0] reqAddr_i,
  output logic                          beatValid_o,
  output logic                          beatLast_o,
  output logic      [`CACHE_WORD_W-1:0] beatData_o
);

  int                       gapSeed = 85762;
  int                       gap;
  logic [`CACHE_ADDR_W-1:0] base;

  // every word holds its own byte address next to its complement
  function automatic logic [`CACHE_WORD_W-1:0] wordAt(input logic [`CACHE_ADDR_W-1:0] a);
    return {a, ~a};
  endfunction

  initial begin
    beatValid_o = 1'b0;
    beatLast_o  = 1'b0;
    beatData_o  = '0;
    forever begin
      @(posedge clk);
      #1;
      if (reqValid_i) begin
        base = reqAddr_i;
        for (int b = 0; b < `CACHE_BEATS; b++) begin
          // idle gap of 0 to 3 cycles ahead of each beat
          gap = {$random(gapSeed)} % 4;
          repeat (gap) begin
            @(posedge clk);
            #1;
          end
          beatValid_o = 1'b1;
          beatLast_o  = (b == `CACHE_BEATS - 1);
          beatData_o  = wordAt(base + b * 8);
          @(posedge clk);
          #1;
          beatValid_o = 1'b0;
          beatLast_o  = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/cacheTb.sv
`timescale 1ns/10ps
`include "cache_consts.svh"
`default_nettype none

module cacheTb;

  localparam int WaitLimit = 300;

  logic                     clk;
  logic                     rst_n;
  logic                     valid;
  logic                     op;
  logic [`CACHE_ADDR_W-1:0] addr;
  logic [`CACHE_WORD_W-1:0] wrData;
  logic [`CACHE_MASK_W-1:0] wrMask;
  logic                     addrOk;
  logic                     dataOk;
  logic [`CACHE_WORD_W-1:0] rdData;
  logic                     memReq;
  logic [`CACHE_ADDR_W-1:0] memAddr;
  logic                     beatValid;
  logic                     beatLast;
  logic [`CACHE_WORD_W-1:0] beatData;
  logic                     accepted;
  logic                     memReqSeen = 1'b0;

  // shadow of the cache contents
  logic [`CACHE_TAG_W-1:0]  shTag   [`CACHE_SETS][`CACHE_WAYS];
  logic                     shValid [`CACHE_SETS][`CACHE_WAYS];
  logic [`CACHE_WORD_W-1:0] shWord  [`CACHE_SETS][`CACHE_WAYS][`CACHE_BEATS];
  logic                     shLru   [`CACHE_SETS];

  // expected outcome of the access in flight
  logic                     expLoad;
  logic                     expHit;
  logic [`CACHE_WORD_W-1:0] expData;
  logic [`CACHE_ADDR_W-1:0] expLine;
  int                       bursts = 0;
  int                       burstBase = 0;
  int                       errors = 0;
  int                       timeouts = 0;
  int                       seed = 85762;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  cacheTop uut (
    .clk, .rst_n,
    .valid_i(valid), .op_i(op), .addr_i(addr), .wr_data_i(wrData), .wr_mask_i(wrMask),
    .addr_ok_o(addrOk), .data_ok_o(dataOk), .rd_data_o(rdData),
    .cacheRdValid_o(memReq), .cacheAddr_o(memAddr),
    .rdDataValid_i(beatValid), .rdLast_i(beatLast), .rdData_i(beatData)
  );

  cacheMemModel mem (
    .clk, .reqValid_i(memReq), .reqAddr_i(memAddr),
    .beatValid_o(beatValid), .beatLast_o(beatLast), .beatData_o(beatData)
  );

  assign accepted = valid && addrOk;

  // one burst per rising edge of the memory request
  always @(negedge clk) begin
    if (memReq && !memReqSeen) begin
      bursts <= bursts + 1;
    end
    memReqSeen <= memReq;
  end

  readData: assert property (@(posedge clk) disable iff (!rst_n)
    dataOk && expLoad |-> rdData == expData)
    else begin
      errors++;
      $display("FAIL %0t: load returned %h, expected %h", $time, $sampled(rdData), expData);
    end

  hitLatency: assert property (@(posedge clk) disable iff (!rst_n)
    dataOk && expHit |-> $past(accepted, 2))
    else begin
      errors++;
      $display("FAIL %0t: hit response not two edges after acceptance", $time);
    end

  burstCount: assert property (@(posedge clk) disable iff (!rst_n)
    dataOk |-> (bursts - burstBase) == (expHit ? 0 : 1))
    else begin
      errors++;
      $display("FAIL %0t: %0d bursts for one access, hit expected %0b", $time,
               bursts - burstBase, expHit);
    end

  refillAddr: assert property (@(posedge clk) disable iff (!rst_n)
    memReq |-> !expHit && memAddr == expLine && memAddr[4:0] == 5'd0)
    else begin
      errors++;
      $display("FAIL %0t: refill request to %h, expected %h", $time,
               $sampled(memAddr), expLine);
    end

  // ready while idle, never ready during a refill
  addrOkLevel: assert property (@(posedge clk) disable iff (!rst_n)
    (!valid || addrOk) && !(memReq && addrOk))
    else begin
      errors++;
      $display("FAIL %0t: addr_ok_o %0b with valid %0b and memory request %0b", $time,
               $sampled(addrOk), $sampled(valid), $sampled(memReq));
    end

  function automatic logic [`CACHE_WORD_W-1:0] memWord(input logic [`CACHE_ADDR_W-1:0] a);
    return {a, ~a};
  endfunction

  // update the shadow for one access and set the expectations
  task automatic predict(input logic isStore, input logic [31:0] a, input logic [63:0] wd,
                         input logic [7:0] wm);
    logic [`CACHE_TAG_W-1:0] tag;
    logic [`CACHE_IDX_W-1:0] idx;
    logic [1:0]              w;
    logic                    wayNow;
    tag     = a[31:11];
    idx     = a[10:5];
    w       = a[4:3];
    expLine = {a[31:5], 5'd0};
    expHit  = 1'b0;
    wayNow  = shLru[idx];
    for (int k = 0; k < `CACHE_WAYS; k++) begin
      if (shValid[idx][k] && shTag[idx][k] == tag) begin
        expHit = 1'b1;
        wayNow = k[0];
      end
    end
    if (!expHit) begin
      shTag[idx][wayNow]   = tag;
      shValid[idx][wayNow] = 1'b1;
      for (int b = 0; b < `CACHE_BEATS; b++) begin
        shWord[idx][wayNow][b] = memWord(expLine + b * 8);
      end
    end
    shLru[idx] = ~wayNow;
    if (isStore) begin
      for (int b = 0; b < `CACHE_MASK_W; b++) begin
        if (wm[b]) begin
          shWord[idx][wayNow][w][b*8 +: 8] = wd[b*8 +: 8];
        end
      end
    end
    expLoad = !isStore;
    expData = shWord[idx][wayNow][w];
  endtask

  task automatic access(input logic isStore, input logic [31:0] a, input logic [63:0] wd,
                        input logic [7:0] wm);
    int t;
    @(posedge clk);
    #1;
    predict(isStore, a, wd, wm);
    burstBase = bursts;
    valid     = 1'b1;
    op        = isStore;
    addr      = a;
    wrData    = wd;
    wrMask    = wm;
    t = 0;
    @(negedge clk);
    while (!addrOk && t < WaitLimit) begin
      @(negedge clk);
      t++;
    end
    if (!addrOk) begin
      timeouts++;
      $display("request to %h was never accepted", a);
    end
    @(posedge clk);
    #1;
    valid = 1'b0;
    t = 0;
    @(negedge clk);
    while (!dataOk && t < WaitLimit) begin
      @(negedge clk);
      t++;
    end
    if (!dataOk) begin
      timeouts++;
      $display("access to %h never completed", a);
    end
  endtask

  initial begin
    logic [31:0] r;
    rst_n   = 1'b0;
    valid   = 1'b0;
    op      = 1'b0;
    addr    = '0;
    wrData  = '0;
    wrMask  = '0;
    expLoad = 1'b0;
    expHit  = 1'b0;
    expData = '0;
    expLine = '0;
    for (int s = 0; s < `CACHE_SETS; s++) begin
      shLru[s]      = 1'b0;
      shValid[s][0] = 1'b0;
      shValid[s][1] = 1'b0;
    end
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // cold load, then a second word of the same line
    access(1'b0, 32'h0000_1048, '0, '0);
    access(1'b0, 32'h0000_1050, '0, '0);
    // partial store merged, then read back
    access(1'b1, 32'h0000_1050, 64'hdead_beef_0123_4567, 8'b1010_0101);
    access(1'b0, 32'h0000_1050, '0, '0);

    // set 9 with tags 0, 1 and 2 as A, B and C
    access(1'b0, 32'h0000_0120, '0, '0);
    access(1'b0, 32'h0000_0928, '0, '0);
    access(1'b0, 32'h0000_0130, '0, '0);
    access(1'b0, 32'h0000_1138, '0, '0);
    access(1'b0, 32'h0000_0128, '0, '0);
    access(1'b0, 32'h0000_0920, '0, '0);
    access(1'b0, 32'h0000_0138, '0, '0);

    // four tags over four sets keeps hits and evictions mixed
    for (int i = 0; i < 200; i++) begin
      r = $random(seed);
      access(r[9], {19'd0, r[1:0], 4'd0, r[3:2], r[8:4]},
             {$random(seed), $random(seed)}, r[17:10]);
    end

    repeat (4) @(posedge clk);
    $display("run complete, %0d check failures, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+rtl
rtl/cache_pkg.sv
rtl/cacheTagArray.sv
rtl/cacheDataArray.sv
rtl/cacheRefill.sv
rtl/cacheCtrl.sv
rtl/cacheTop.sv
tests/cacheMemModel.sv
tests/cacheTb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, and pass only if the pass line shows up
verilator --binary --timing --assert --top-module cacheTb -f vlog.f -o cacheSim \
  && ./obj_dir/cacheSim | awk '{ print } /^Testbench passed$/ { ok = 1 } END { exit !ok }' \
  || { echo "simulation did not pass"; exit 1; }
